// File: all.f
src/cache_geom_pkg.sv
src/dir_msg_pkg.sv
src/req_decode.sv
src/plru_tree.sv
src/tag_lookup.sv
src/lookup_result.sv
src/tag_dir_top.sv
verification/tag_dir_checker.sv
verification/tag_dir_tb.sv

// File: run_verilator.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass message
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module tag_dir_tb -f all.f -o tag_dir_sim \
    && ./obj_dir/tag_dir_sim +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -qF '*** TEST PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/cache_geom_pkg.sv
package cache_geom_pkg;

    // 4-way set-associative geometry over a 32-bit byte address
    localparam int way_num  = 4;
    localparam int set_num  = 64;

    // 64-byte lines
    localparam int offset_w = 6;
    localparam int index_w  = 6;

    // whatever is left above index and offset
    localparam int tag_w    = 20;

    // enough bits to number the ways
    localparam int way_w    = 2;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] set_idx_t;

    // one bit per way, at most one set
    typedef logic [way_num-1:0] way_oh_t;

    // tree bits for 4 ways
    // bit 0 is the root, bit 1 picks in ways 0-1, bit 2 picks in ways 2-3
    typedef logic [way_num-2:0] plru_bits_t;

endpackage

// File: src/dir_msg_pkg.sv
package dir_msg_pkg;

    import cache_geom_pkg::*;

    typedef enum logic [1:0] {
        op_none   = 2'd0,
        op_lookup = 2'd1,
        op_inval  = 2'd2
    } dir_op_e;

    // operand read as a memory address
    typedef struct packed {
        tag_t                  tag;
        set_idx_t              index;
        logic [offset_w-1:0]   offset;
    } cache_addr_t;

    // operand read as a set/way pair for maintenance ops
    typedef struct packed {
        logic [31-index_w-way_w:0] rsvd;
        set_idx_t                  set;
        logic [way_w-1:0]          way;
    } maint_addr_t;

    // same 32 bits, meaning depends on the opcode
    typedef union packed {
        cache_addr_t addr;
        maint_addr_t maint;
    } operand_u;

    typedef struct packed {
        dir_op_e  op;
        operand_u operand;
    } dir_req_t;

    // decoded request, already split by opcode
    typedef struct packed {
        logic             valid;
        logic             inval;
        set_idx_t         set;
        tag_t             tag;
        logic [way_w-1:0] way;
    } dec_req_t;

    typedef struct packed {
        logic     valid;
        logic     hit;
        way_oh_t  way_oh;
        logic     evict_valid;
        tag_t     evict_tag;
        logic     inval_done;
    } dir_rsp_t;

endpackage

// File: src/lookup_result.sv
`timescale 1ns/1ns

module lookup_result
    import dir_msg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  dir_rsp_t    stage,
    output dir_rsp_t    rsp,
    output logic [15:0] hit_count,
    output logic [15:0] miss_count
);

    dir_rsp_t rsp_q;
    logic     rsp_valid_q;
    logic     is_lookup;

    // invalidates are not counted
    assign is_lookup = stage.valid && !stage.inval_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
            hit_count   <= '0;
            miss_count  <= '0;
        end else begin
            rsp_valid_q <= stage.valid;
            // both counters stick at all ones
            if (is_lookup && stage.hit && (hit_count != 16'hffff)) begin
                hit_count <= hit_count + 16'd1;
            end
            if (is_lookup && !stage.hit && (miss_count != 16'hffff)) begin
                miss_count <= miss_count + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rsp_q <= stage;
    end

    always_comb begin
        rsp       = rsp_q;
        rsp.valid = rsp_valid_q;
    end

endmodule

// File: src/plru_tree.sv
`timescale 1ns/1ns

module plru_tree
    import cache_geom_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  set_idx_t rd_set,
    input  logic     touch,
    input  set_idx_t touch_set,
    input  way_oh_t  touch_way,
    input  logic     touch_inval,
    output way_oh_t  victim
);

    plru_bits_t       tree_q [set_num];
    plru_bits_t       rd_bits;
    plru_bits_t       cur_bits;
    plru_bits_t       next_bits;
    logic [way_w-1:0] touch_idx;
    logic             away;

    // victim walk over the tree of the set being read
    assign rd_bits = tree_q[rd_set];

    always_comb begin
        victim = '0;
        if (rd_bits[0]) begin
            // root says ways 2-3, node 2 picks between them
            if (rd_bits[2]) begin
                victim[3] = 1'b1;
            end else begin
                victim[2] = 1'b1;
            end
        end else begin
            // node 1 picks between ways 0 and 1
            if (rd_bits[1]) begin
                victim[1] = 1'b1;
            end else begin
                victim[0] = 1'b1;
            end
        end
    end

    // one-hot way to way number
    always_comb begin
        touch_idx = '0;
        for (int i = 0; i < way_num; i++) begin
            if (touch_way[i]) begin
                touch_idx = way_w'(i);
            end
        end
    end

    // a normal touch points the path away from the way
    // an invalidate points it toward the way so it is refilled next
    assign away     = ~touch_inval;
    assign cur_bits = tree_q[touch_set];

    always_comb begin
        next_bits    = cur_bits;
        next_bits[0] = touch_idx[1] ^ away;
        if (touch_idx[1]) begin
            next_bits[2] = touch_idx[0] ^ away;
        end else begin
            next_bits[1] = touch_idx[0] ^ away;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < set_num; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[touch_set] <= next_bits;
        end
    end

endmodule

// File: src/req_decode.sv
`timescale 1ns/1ns

module req_decode
    import cache_geom_pkg::*;
    import dir_msg_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  dir_req_t req,
    output dec_req_t dec
);

    logic             fwd;
    logic             is_inval;
    set_idx_t         set_d;
    tag_t             tag_d;
    logic [way_w-1:0] way_d;

    logic             valid_q;
    logic             inval_q;
    set_idx_t         set_q;
    tag_t             tag_q;
    logic [way_w-1:0] way_q;

    // op_none is dropped here and never reaches the arrays
    assign fwd      = req_valid && (req.op != op_none);
    assign is_inval = (req.op == op_inval);

    // pick the field layout by opcode
    always_comb begin
        if (is_inval) begin
            set_d = req.operand.maint.set;
            way_d = req.operand.maint.way;
            // tag is not looked at for invalidates
            tag_d = '0;
        end else begin
            set_d = req.operand.addr.index;
            tag_d = req.operand.addr.tag;
            way_d = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            inval_q <= 1'b0;
        end else begin
            valid_q <= fwd;
            inval_q <= is_inval;
        end
    end

    // address fields, qualified by valid_q
    always_ff @(posedge clk) begin
        set_q <= set_d;
        tag_q <= tag_d;
        way_q <= way_d;
    end

    always_comb begin
        dec.valid = valid_q;
        dec.inval = inval_q;
        dec.set   = set_q;
        dec.tag   = tag_q;
        dec.way   = way_q;
    end

endmodule

// File: src/tag_dir_top.sv
`timescale 1ns/1ns

module tag_dir_top
    import dir_msg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  dir_req_t    req,
    output dir_rsp_t    rsp,
    output logic [15:0] hit_count,
    output logic [15:0] miss_count
);

    dec_req_t dec;
    dir_rsp_t stage;

    // decode -> execute -> result, one register per stage
    req_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .dec       (dec)
    );

    tag_lookup u_lookup (
        .clk   (clk),
        .rst   (rst),
        .dec   (dec),
        .stage (stage)
    );

    lookup_result u_result (
        .clk        (clk),
        .rst        (rst),
        .stage      (stage),
        .rsp        (rsp),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

endmodule

// File: src/tag_lookup.sv
`timescale 1ns/1ns

module tag_lookup
    import cache_geom_pkg::*;
    import dir_msg_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  dec_req_t dec,
    output dir_rsp_t stage
);

    tag_t     tag_mem [set_num][way_num];
    way_oh_t  valid_q [set_num];

    tag_t     rd_tags [way_num];
    way_oh_t  rd_valid;
    way_oh_t  hit_oh;
    logic     hit;
    way_oh_t  free_oh;
    way_oh_t  victim;
    way_oh_t  alloc_oh;
    way_oh_t  inval_oh;
    way_oh_t  touch_oh;
    logic     evict;
    tag_t     evict_tag;
    logic     do_alloc;

    dir_rsp_t next_rsp;
    dir_rsp_t rsp_q;
    logic     stage_valid_q;

    // read the whole set, compare all four ways at once
    always_comb begin
        rd_valid = valid_q[dec.set];
        for (int i = 0; i < way_num; i++) begin
            rd_tags[i] = tag_mem[dec.set][i];
            hit_oh[i]  = rd_valid[i] && (rd_tags[i] == dec.tag);
        end
    end

    assign hit = |hit_oh;

    // lowest invalid way wins over the tree victim
    always_comb begin
        free_oh = '0;
        for (int i = way_num - 1; i >= 0; i--) begin
            if (!rd_valid[i]) begin
                free_oh    = '0;
                free_oh[i] = 1'b1;
            end
        end
    end

    assign alloc_oh = (&rd_valid) ? victim : free_oh;
    assign inval_oh = way_oh_t'(1) << dec.way;
    assign do_alloc = dec.valid && !dec.inval && !hit;

    // old tag of the replaced way, only meaningful if it was valid
    always_comb begin
        evict_tag = '0;
        for (int i = 0; i < way_num; i++) begin
            if (alloc_oh[i]) begin
                evict_tag = rd_tags[i];
            end
        end
    end

    assign evict    = !hit && |(alloc_oh & rd_valid);
    assign touch_oh = dec.inval ? inval_oh : (hit ? hit_oh : alloc_oh);

    plru_tree u_plru (
        .clk         (clk),
        .rst         (rst),
        .rd_set      (dec.set),
        .touch       (dec.valid),
        .touch_set   (dec.set),
        .touch_way   (touch_oh),
        .touch_inval (dec.inval),
        .victim      (victim)
    );

    // valid bits: set on allocate, cleared on invalidate
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < set_num; s++) begin
                valid_q[s] <= '0;
            end
        end else if (dec.valid) begin
            if (dec.inval) begin
                valid_q[dec.set] <= rd_valid & ~inval_oh;
            end else if (!hit) begin
                valid_q[dec.set] <= rd_valid | alloc_oh;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < way_num; i++) begin
            if (do_alloc && alloc_oh[i]) begin
                tag_mem[dec.set][i] <= dec.tag;
            end
        end
    end

    // response for this request
    always_comb begin
        next_rsp.valid       = dec.valid;
        next_rsp.hit         = !dec.inval && hit;
        next_rsp.way_oh      = touch_oh;
        next_rsp.evict_valid = !dec.inval && evict;
        next_rsp.evict_tag   = evict_tag;
        next_rsp.inval_done  = dec.inval;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid_q <= 1'b0;
        end else begin
            stage_valid_q <= next_rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp_q <= next_rsp;
    end

    always_comb begin
        stage       = rsp_q;
        stage.valid = stage_valid_q;
    end

endmodule

// File: verification/tag_dir_checker.sv
`timescale 1ns/1ns

module tag_dir_checker
    import dir_msg_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     req_valid,
    input dir_req_t req,
    input dir_rsp_t rsp
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    logic sent;

    // op_none never produces a response
    assign sent = req_valid && (req.op != op_none);

    // a response exactly three edges after each real request, and at no other time
    rsp_timing: assert property (@(posedge clk) disable iff (rst) rsp.valid == $past(sent, 3))
        else begin
            $error("rsp.valid does not follow the request by three cycles");
            fail_count++;
        end

    rsp_way_onehot: assert property (@(posedge clk) disable iff (rst)
        rsp.valid |-> $onehot(rsp.way_oh))
        else begin
            $error("rsp.way_oh is not one-hot on a valid response");
            fail_count++;
        end

    rsp_quiet_in_reset: assert property (@(posedge clk) rst |-> !rsp.valid)
        else begin
            $error("rsp.valid is high during reset");
            fail_count++;
        end

    // a hit never replaces anything
    hit_no_evict: assert property (@(posedge clk) disable iff (rst)
        (rsp.valid && rsp.hit) |-> !rsp.evict_valid)
        else begin
            $error("evict_valid set on a hit");
            fail_count++;
        end

endmodule

bind tag_dir_top tag_dir_checker chk_i (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rsp       (rsp)
);

// File: verification/tag_dir_tb.sv
`timescale 1ns/1ns

module tag_dir_tb
    import cache_geom_pkg::*;
    import dir_msg_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        req_valid;
    dir_req_t    req;
    dir_rsp_t    rsp;
    logic [15:0] hit_count;
    logic [15:0] miss_count;

    // reference model of the directory
    tag_t       tag_m [set_num][way_num];
    way_oh_t    val_m [set_num];
    plru_bits_t tree_m [set_num];
    dir_rsp_t   exp_q [$];
    int         hits_m;
    int         misses_m;
    int         errors;
    int         tests;
    tag_t       t [way_num];
    tag_t       old_tag;

    tag_dir_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .rsp        (rsp),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // root set sends the victim to ways 2-3
    function automatic int plru_victim(plru_bits_t b);
        if (b[0]) begin
            return b[2] ? 3 : 2;
        end
        return b[1] ? 1 : 0;
    endfunction

    // normal touch points root and pair node away from w, invalidate points them at w
    task automatic tree_touch(int s, int w, bit inval);
        bit upper;
        bit odd;
        upper = (w >= 2);
        odd   = (w % 2) == 1;
        tree_m[s][0] = inval ? upper : !upper;
        if (upper) begin
            tree_m[s][2] = inval ? odd : !odd;
        end else begin
            tree_m[s][1] = inval ? odd : !odd;
        end
    endtask

    task automatic model_lookup(int s, tag_t tag, output dir_rsp_t e);
        int w;
        w = -1;
        e = '0;
        e.valid = 1'b1;
        for (int i = 0; i < way_num; i++) begin
            if (val_m[s][i] && tag_m[s][i] == tag) begin
                w = i;
            end
        end
        if (w >= 0) begin
            e.hit = 1'b1;
            hits_m++;
        end else begin
            misses_m++;
            // lowest free way first
            for (int i = way_num - 1; i >= 0; i--) begin
                if (!val_m[s][i]) begin
                    w = i;
                end
            end
            if (w < 0) begin
                w = plru_victim(tree_m[s]);
                e.evict_valid = 1'b1;
                e.evict_tag   = tag_m[s][w];
            end
            tag_m[s][w] = tag;
            val_m[s][w] = 1'b1;
        end
        e.way_oh = way_oh_t'(1) << w;
        tree_touch(s, w, 1'b0);
    endtask

    // one request, held for one cycle; the model follows in issue order
    task automatic send(dir_op_e op, int s, tag_t tag, int w);
        dir_rsp_t e;
        operand_u u;
        u = operand_u'($urandom);
        if (op == op_inval) begin
            u.maint.set = set_idx_t'(s);
            u.maint.way = way_w'(w);
        end else begin
            u.addr.tag   = tag;
            u.addr.index = set_idx_t'(s);
        end
        @(posedge clk);
        #2;
        req_valid   = 1'b1;
        req.op      = op;
        req.operand = u;
        if (op == op_lookup) begin
            model_lookup(s, tag, e);
            exp_q.push_back(e);
        end else if (op == op_inval) begin
            e = '0;
            e.valid      = 1'b1;
            e.way_oh     = way_oh_t'(1) << w;
            e.inval_done = 1'b1;
            val_m[s][w]  = 1'b0;
            tree_touch(s, w, 1'b1);
            exp_q.push_back(e);
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        req       = '0;
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] want);
        assert (got == want) else begin
            $display("MISMATCH %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // compare every response against the head of the queue
    always @(negedge clk) begin
        dir_rsp_t e;
        if (!rst && rsp.valid) begin
            if (exp_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                errors++;
            end else begin
                e = exp_q.pop_front();
                check("rsp.hit", 32'(rsp.hit), 32'(e.hit));
                check("rsp.way_oh", 32'(rsp.way_oh), 32'(e.way_oh));
                check("rsp.evict_valid", 32'(rsp.evict_valid), 32'(e.evict_valid));
                check("rsp.inval_done", 32'(rsp.inval_done), 32'(e.inval_done));
                if (e.evict_valid) begin
                    check("rsp.evict_tag", 32'(rsp.evict_tag), 32'(e.evict_tag));
                end
            end
        end
    end

    // wait for all responses, then compare the counters
    task automatic finish_test(string name);
        int n;
        n = 0;
        idle();
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s, %0d responses never arrived", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
        #1;
        check("hit_count", 32'(hit_count), 32'(hits_m));
        check("miss_count", 32'(miss_count), 32'(misses_m));
        tests++;
        $display("test %0d %s finished, %0d errors so far", tests, name, errors);
    endtask

    initial begin
        void'($urandom(32'he9f7_392f));
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        hits_m = 0;
        misses_m = 0;
        errors = 0;
        tests = 0;
        for (int s = 0; s < set_num; s++) begin
            val_m[s]  = '0;
            tree_m[s] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // distinct tags, low bits forced apart
        for (int i = 0; i < way_num; i++) begin
            t[i] = tag_t'($urandom);
            t[i][1:0] = 2'(i);
        end
        for (int i = 0; i < way_num; i++) begin
            send(op_lookup, 5, t[i], 0);
        end
        finish_test("cold_fill");

        for (int i = 0; i < way_num; i++) begin
            send(op_lookup, 5, t[i], 0);
        end
        finish_test("relookup_hits");

        // touches then two new tags, all back to back in one set
        send(op_lookup, 5, t[3], 0);
        send(op_lookup, 5, t[1], 0);
        send(op_lookup, 5, tag_t'($urandom) | 20'h80000, 0);
        send(op_lookup, 5, tag_t'($urandom) & 20'h7fff0, 0);
        finish_test("plru_evict");

        old_tag = tag_m[5][1];
        send(op_inval, 5, '0, 1);
        send(op_lookup, 5, old_tag, 0);
        finish_test("inval_refill");

        // small tag pool over four sets so hits and evictions both happen
        for (int i = 0; i < 300; i++) begin
            case ($urandom % 16)
                0, 1: send(op_inval, int'($urandom % 4), '0, int'($urandom % 4));
                2: send(op_none, 0, '0, 0);
                default: send(op_lookup, int'($urandom % 4), tag_t'(20'h100 + $urandom % 7), 0);
            endcase
        end
        finish_test("random_mix");

        errors += dut_i.chk_i.fail_count;
        $display("%0d tests run, %0d checks failed", tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
